/* run_sim.sh */
#!/bin/sh
# build and run the dma subsystem testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f \
    --top-module dma_subsystem_tb -Mdir obj_dir -o dma_subsystem_sim
# assertion errors do not end the run, the testbench stops on them
./obj_dir/dma_subsystem_sim +verilator+error+limit+100 | tee sim.log
if grep -q "Result: PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* source/chip_select.sv */
`timescale 1ns/1ps

module chip_select #(
    parameter logic [7:0] DMA_ADDR = 8'h00
) (
    input  logic       wb_clk,
    input  logic       wb_rst,
    input  logic       cyc,
    input  logic [7:0] addr,
    output logic       hit,
    output logic       ack
);

    // set once the open cycle has had its ack
    logic served;

    assign hit = cyc && (addr == DMA_ADDR);

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            ack    <= 1'b0;
            served <= 1'b0;
        end else begin
            ack    <= hit && !served;
            // rearm only when the master drops cyc
            served <= cyc && (served || hit);
        end
    end

endmodule

/* source/dma.sv */
`timescale 1ns/1ps

module dma #(
    parameter logic [7:0] DMA_ADDR    = 8'h00,
    parameter int         XFER_ADDR_W = 3
) (
    input  logic                   wb_clk,
    input  logic                   wb_rst,
    input  dma_pkg::cpu_req_t      cpu_req,
    output dma_pkg::cpu_rsp_t      cpu_rsp,
    input  logic                   xfer_block,
    output logic [XFER_ADDR_W-1:0] xfer_adr,
    output logic                   xfer_re,
    input  dma_pkg::sample_t       xfer_dat,
    output dma_pkg::dma_req_t      dma_req,
    input  logic                   dma_ack,
    output logic                   block_done,
    output logic                   xfer_done,
    output logic                   xfer_match
);

    logic        cs_hit;
    logic        cs_ack;
    logic [2:0]  io_idx;
    logic [31:0] rd_word;
    // register file
    logic [23:0] reg_addr;
    logic [15:0] reg_step;
    logic [15:0] reg_cycles;
    logic [15:0] reg_blocks;
    logic [23:0] reg_match;
    logic        start_req;
    logic        repeat_mode;
    // run and block state
    logic        running;
    logic        block_en;
    logic [23:0] run_addr;
    logic [15:0] run_cycles;
    logic [15:0] block_cnt;
    logic [23:0] addr;
    // memory bus master
    logic        bus_cyc;
    logic        bus_done;
    logic [31:0] half_data;

    chip_select #(.DMA_ADDR(DMA_ADDR)) u_cs (
        .wb_clk (wb_clk),
        .wb_rst (wb_rst),
        .cyc    (cpu_req.cyc),
        .addr   (cpu_req.adr[31:24]),
        .hit    (cs_hit),
        .ack    (cs_ack)
    );

    assign io_idx = cpu_req.adr[4:2];

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            reg_addr    <= '0;
            reg_step    <= '0;
            reg_cycles  <= '0;
            reg_blocks  <= '0;
            reg_match   <= '0;
            start_req   <= 1'b0;
            repeat_mode <= 1'b0;
        end else begin
            // in repeat mode done drops start for a cycle, forcing a reload
            if (xfer_done && repeat_mode && running) begin
                start_req <= ~start_req;
            end
            if (cs_hit && cpu_req.we) begin
                case (io_idx)
                    dma_pkg::REG_ADDR:   reg_addr   <= cpu_req.dat[23:0];
                    dma_pkg::REG_STEP:   reg_step   <= cpu_req.dat[15:0];
                    dma_pkg::REG_CYCLES: reg_cycles <= cpu_req.dat[15:0];
                    dma_pkg::REG_BLOCKS: reg_blocks <= cpu_req.dat[15:0];
                    dma_pkg::REG_MATCH:  reg_match  <= cpu_req.dat[23:0];
                    dma_pkg::REG_START: begin
                        start_req   <= 1'b1;
                        repeat_mode <= cpu_req.dat[0];
                    end
                    dma_pkg::REG_STOP: begin
                        start_req   <= 1'b0;
                        repeat_mode <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    // readback, start and stop read as zero
    always_comb begin
        rd_word = '0;
        case (io_idx)
            dma_pkg::REG_ADDR:   rd_word = {8'h00, reg_addr};
            dma_pkg::REG_STEP:   rd_word = {16'h0000, reg_step};
            dma_pkg::REG_CYCLES: rd_word = {16'h0000, reg_cycles};
            dma_pkg::REG_BLOCKS: rd_word = {16'h0000, reg_blocks};
            dma_pkg::REG_MATCH:  rd_word = {8'h00, reg_match};
            dma_pkg::REG_STATUS: begin
                rd_word[dma_pkg::STAT_DONE]  = xfer_done;
                rd_word[dma_pkg::STAT_BLOCK] = block_done;
                rd_word[dma_pkg::STAT_MATCH] = xfer_match;
            end
            default: rd_word = '0;
        endcase
    end

    assign cpu_rsp.ack = cs_ack;
    assign cpu_rsp.dat = (cs_ack && !cpu_req.we) ? rd_word : 32'h0;

    assign bus_done = bus_cyc && dma_ack;

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            running    <= 1'b0;
            block_en   <= 1'b0;
            run_addr   <= '0;
            run_cycles <= '0;
            block_cnt  <= '0;
            addr       <= '0;
            xfer_adr   <= '0;
            bus_cyc    <= 1'b0;
            block_done <= 1'b0;
            xfer_done  <= 1'b0;
            xfer_match <= 1'b0;
        end else begin
            // load the run the cycle after start
            if (start_req && !running) begin
                running    <= 1'b1;
                run_addr   <= reg_addr;
                run_cycles <= reg_cycles;
                block_cnt  <= reg_blocks;
                block_done <= 1'b0;
                xfer_done  <= 1'b0;
                xfer_match <= 1'b0;
            end
            // a full bank is waiting
            if (start_req && running && xfer_block && !xfer_done) begin
                block_en   <= 1'b1;
                addr       <= run_addr;
                block_cnt  <= reg_blocks;
                xfer_adr   <= '0;
                block_done <= 1'b0;
            end
            if (start_req && block_en && !bus_cyc) begin
                bus_cyc <= 1'b1;
            end
            if (bus_done) begin
                bus_cyc   <= 1'b0;
                addr      <= addr + {8'h00, reg_step};
                xfer_adr  <= xfer_adr + 1'b1;
                block_cnt <= block_cnt - 16'd1;
                // last transfer, next block starts one half-word on
                if (block_en && (block_cnt == 16'd1)) begin
                    block_en   <= 1'b0;
                    run_cycles <= run_cycles - 16'd1;
                    run_addr   <= run_addr + 24'd2;
                end
            end
            if (start_req && block_en && (reg_match != 24'h0) && (addr == reg_match)) begin
                xfer_match <= 1'b1;
            end
            if (running && (block_cnt == 16'd0) && !block_en && !xfer_block) begin
                block_done <= 1'b1;
                if (run_cycles == 16'd0) begin
                    xfer_done <= 1'b1;
                end
            end
            // stop or reload wins over everything above
            if (!start_req) begin
                running    <= 1'b0;
                block_en   <= 1'b0;
                block_done <= 1'b0;
                xfer_done  <= 1'b0;
                xfer_match <= 1'b0;
            end
        end
    end

    // addr only moves on ack, so address and lane hold for the whole cycle
    assign half_data   = addr[1] ? {xfer_dat, 16'h0000} : {16'h0000, xfer_dat};
    assign dma_req.cyc = bus_cyc;
    assign dma_req.we  = bus_cyc;
    assign dma_req.sel = bus_cyc ? (addr[1] ? 4'b1100 : 4'b0011) : 4'b0000;
    assign dma_req.adr = bus_cyc ? {8'h00, addr[23:2], 2'b00} : 32'h0;
    assign dma_req.dat = bus_done ? half_data : 32'h0;

    assign xfer_re = block_en && bus_done;

endmodule

/* source/dma_pkg.sv */
package dma_pkg;

    // one audio sample from the capture port
    typedef logic [15:0] sample_t;

    // cpu register bus request
    typedef struct packed {
        logic        cyc;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } cpu_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } cpu_rsp_t;

    // memory bus, the engine only ever writes
    typedef struct packed {
        logic        cyc;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } dma_req_t;

    // register word index, taken from address bits 4:2
    localparam logic [2:0] REG_ADDR   = 3'd0;
    localparam logic [2:0] REG_STEP   = 3'd1;
    localparam logic [2:0] REG_CYCLES = 3'd2;
    localparam logic [2:0] REG_BLOCKS = 3'd3;
    localparam logic [2:0] REG_START  = 3'd4;
    localparam logic [2:0] REG_STOP   = 3'd5;
    localparam logic [2:0] REG_STATUS = 3'd6;
    localparam logic [2:0] REG_MATCH  = 3'd7;

    // bits of the status word
    localparam int STAT_DONE  = 0;
    localparam int STAT_BLOCK = 1;
    localparam int STAT_MATCH = 2;

endpackage

/* source/dma_subsystem.sv */
`timescale 1ns/1ps

module dma_subsystem #(
    parameter logic [7:0] DMA_ADDR    = 8'h40,
    parameter int         XFER_ADDR_W = 3
) (
    input  logic              wb_clk,
    input  logic              wb_rst,
    input  dma_pkg::cpu_req_t cpu_req,
    output dma_pkg::cpu_rsp_t cpu_rsp,
    input  logic              sample_valid,
    input  dma_pkg::sample_t  sample_data,
    output dma_pkg::dma_req_t dma_req,
    input  logic              dma_ack,
    output logic              block_done,
    output logic              xfer_done,
    output logic              xfer_match
);

    // producer side
    logic                   wr_en;
    logic [XFER_ADDR_W-1:0] wr_adr;
    dma_pkg::sample_t       wr_data;
    logic                   fill_bank;
    logic                   block_ready;
    // consumer side
    logic [XFER_ADDR_W-1:0] xfer_adr;
    dma_pkg::sample_t       xfer_dat;

    sample_capture #(.XFER_ADDR_W(XFER_ADDR_W)) u_capture (
        .wb_clk       (wb_clk),
        .wb_rst       (wb_rst),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .wr_en        (wr_en),
        .wr_adr       (wr_adr),
        .wr_data      (wr_data),
        .fill_bank    (fill_bank),
        .block_ready  (block_ready)
    );

    sample_buffer #(.XFER_ADDR_W(XFER_ADDR_W)) u_buffer (
        .wb_clk    (wb_clk),
        .wr_en     (wr_en),
        .wr_adr    (wr_adr),
        .wr_data   (wr_data),
        .fill_bank (fill_bank),
        .rd_adr    (xfer_adr),
        .rd_data   (xfer_dat)
    );

    dma #(
        .DMA_ADDR    (DMA_ADDR),
        .XFER_ADDR_W (XFER_ADDR_W)
    ) u_dma (
        .wb_clk     (wb_clk),
        .wb_rst     (wb_rst),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .xfer_block (block_ready),
        .xfer_adr   (xfer_adr),
        .xfer_re    (),
        .xfer_dat   (xfer_dat),
        .dma_req    (dma_req),
        .dma_ack    (dma_ack),
        .block_done (block_done),
        .xfer_done  (xfer_done),
        .xfer_match (xfer_match)
    );

endmodule

/* source/sample_buffer.sv */
`timescale 1ns/1ps

module sample_buffer #(
    parameter int XFER_ADDR_W = 3
) (
    input  logic                   wb_clk,
    input  logic                   wr_en,
    input  logic [XFER_ADDR_W-1:0] wr_adr,
    input  dma_pkg::sample_t       wr_data,
    input  logic                   fill_bank,
    input  logic [XFER_ADDR_W-1:0] rd_adr,
    output dma_pkg::sample_t       rd_data
);

    // two banks, bank number is the top address bit
    localparam int DEPTH = 2 << XFER_ADDR_W;

    dma_pkg::sample_t mem [DEPTH];

    always_ff @(posedge wb_clk) begin
        if (wr_en) begin
            mem[{fill_bank, wr_adr}] <= wr_data;
        end
    end

    // engine side sees the bank that was last completed
    assign rd_data = mem[{~fill_bank, rd_adr}];

endmodule

/* source/sample_capture.sv */
`timescale 1ns/1ps

module sample_capture #(
    parameter int XFER_ADDR_W = 3
) (
    input  logic                   wb_clk,
    input  logic                   wb_rst,
    input  logic                   sample_valid,
    input  dma_pkg::sample_t       sample_data,
    output logic                   wr_en,
    output logic [XFER_ADDR_W-1:0] wr_adr,
    output dma_pkg::sample_t       wr_data,
    output logic                   fill_bank,
    output logic                   block_ready
);

    // slot of the next sample within the fill bank
    logic [XFER_ADDR_W-1:0] count;
    logic                   last_slot;

    assign last_slot = (count == {XFER_ADDR_W{1'b1}});

    // each valid sample goes straight into the fill bank
    assign wr_en   = sample_valid;
    assign wr_adr  = count;
    assign wr_data = sample_data;

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            count       <= '0;
            fill_bank   <= 1'b0;
            block_ready <= 1'b0;
        end else begin
            // one pulse, the clock after the bank is full
            block_ready <= sample_valid && last_slot;
            if (sample_valid) begin
                count <= count + 1'b1;
                // hand the full bank to the engine
                if (last_slot) begin
                    fill_bank <= ~fill_bank;
                end
            end
        end
    end

endmodule

/* tb/dma_subsystem_asserts.sv */
`timescale 1ns/1ps

module dma_subsystem_asserts #(
    parameter logic [7:0] DMA_ADDR = 8'h40
) (
    input logic              wb_clk,
    input logic              wb_rst,
    input dma_pkg::cpu_req_t cpu_req,
    input dma_pkg::cpu_rsp_t cpu_rsp,
    input dma_pkg::dma_req_t dma_req,
    input logic              dma_ack,
    input logic              block_done,
    input logic              xfer_done,
    input logic              xfer_match
);

    int unsigned violations = 0;
    logic        hit;

    assign hit = cpu_req.cyc && (cpu_req.adr[31:24] == DMA_ADDR);

    // register bus ack exactly one clock after the first hit
    ack_after_hit: assert property (@(posedge wb_clk) disable iff (wb_rst)
        $rose(hit) |=> cpu_rsp.ack)
    else begin
        violations = violations + 1;
        $error("register bus ack missing one cycle after hit");
    end

    ack_needs_hit: assert property (@(posedge wb_clk) disable iff (wb_rst)
        cpu_rsp.ack |-> $past(hit) && cpu_req.cyc)
    else begin
        violations = violations + 1;
        $error("register bus ack without a preceding hit");
    end

    ack_single: assert property (@(posedge wb_clk) disable iff (wb_rst)
        cpu_rsp.ack |=> !cpu_rsp.ack)
    else begin
        violations = violations + 1;
        $error("register bus ack longer than one cycle");
    end

    // request held steady while the memory stalls
    dma_hold: assert property (@(posedge wb_clk) disable iff (wb_rst)
        dma_req.cyc && !dma_ack |=> dma_req.cyc && $stable(dma_req.adr)
            && $stable(dma_req.sel) && $stable(dma_req.we))
    else begin
        violations = violations + 1;
        $error("memory request changed before ack");
    end

    dma_sel_legal: assert property (@(posedge wb_clk) disable iff (wb_rst)
        dma_req.cyc |-> dma_req.we && (dma_req.sel == 4'b0011 || dma_req.sel == 4'b1100))
    else begin
        violations = violations + 1;
        $error("illegal byte select or missing we on memory bus");
    end

    dma_data_idle: assert property (@(posedge wb_clk) disable iff (wb_rst)
        !(dma_req.cyc && dma_ack) |-> dma_req.dat == 32'h0)
    else begin
        violations = violations + 1;
        $error("memory bus data driven outside ack");
    end

    dma_gap: assert property (@(posedge wb_clk) disable iff (wb_rst)
        dma_req.cyc && dma_ack |=> !dma_req.cyc)
    else begin
        violations = violations + 1;
        $error("memory cycle not dropped after ack");
    end

    reset_state: assert property (@(posedge wb_clk)
        $fell(wb_rst) |-> !dma_req.cyc && dma_req.sel == 4'h0 && !cpu_rsp.ack
            && !block_done && !xfer_done && !xfer_match)
    else begin
        violations = violations + 1;
        $error("outputs not idle after reset");
    end

endmodule

bind dma_subsystem dma_subsystem_asserts #(.DMA_ADDR(DMA_ADDR)) u_asserts (
    .wb_clk     (wb_clk),
    .wb_rst     (wb_rst),
    .cpu_req    (cpu_req),
    .cpu_rsp    (cpu_rsp),
    .dma_req    (dma_req),
    .dma_ack    (dma_ack),
    .block_done (block_done),
    .xfer_done  (xfer_done),
    .xfer_match (xfer_match)
);

/* tb/dma_subsystem_tb.sv */
`timescale 1ns/1ps

module dma_subsystem_tb;

    localparam logic [7:0]  DMA_ADDR    = 8'h40;
    localparam int          XFER_ADDR_W = 3;
    localparam int          BANK_SIZE   = 1 << XFER_ADDR_W;
    localparam int          WAIT_LIMIT  = 200;
    // run setup
    localparam logic [23:0] START_ADDR  = 24'h000102;
    localparam logic [15:0] STEP        = 16'h0006;
    localparam int          NUM_BLOCKS  = 3;
    localparam int          PER_BLOCK   = 4;
    // second transfer of the second block
    localparam logic [23:0] MATCH_ADDR  = 24'h00010A;

    logic              wb_clk = 1'b0;
    logic              wb_rst = 1'b1;
    dma_pkg::cpu_req_t cpu_req = '0;
    dma_pkg::cpu_rsp_t cpu_rsp;
    logic              sample_valid = 1'b0;
    dma_pkg::sample_t  sample_data = '0;
    dma_pkg::dma_req_t dma_req;
    logic              dma_ack = 1'b0;
    logic              block_done;
    logic              xfer_done;
    logic              xfer_match;
    logic [15:0]       lfsr = 16'd29440;
    dma_pkg::sample_t  next_sample = 16'h5A00;

    always #5 wb_clk = ~wb_clk;

    dma_subsystem #(
        .DMA_ADDR    (DMA_ADDR),
        .XFER_ADDR_W (XFER_ADDR_W)
    ) DUT (
        .wb_clk       (wb_clk),
        .wb_rst       (wb_rst),
        .cpu_req      (cpu_req),
        .cpu_rsp      (cpu_rsp),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .dma_req      (dma_req),
        .dma_ack      (dma_ack),
        .block_done   (block_done),
        .xfer_done    (xfer_done),
        .xfer_match   (xfer_match)
    );

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s", what);
        stop_run();
    endtask

    task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got == exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    // protocol assertions live in the bound checker
    always @(negedge wb_clk) begin
        if (DUT.u_asserts.violations != 0) begin
            $display("a bus protocol assertion failed");
            stop_run();
        end
    end

    // galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per delay bit
    task automatic draw_delay(output int d);
        d = 0;
        repeat (2) begin
            d = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic cpu_access(input logic we, input logic [2:0] idx,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int n;
        @(negedge wb_clk);
        cpu_req.cyc = 1'b1;
        cpu_req.we  = we;
        cpu_req.adr = {DMA_ADDR, 19'h0, idx, 2'b00};
        cpu_req.dat = wdat;
        n = 0;
        do begin
            @(negedge wb_clk);
            n++;
            if (n > WAIT_LIMIT) give_up("no ack on the register bus");
        end while (!cpu_rsp.ack);
        rdat = cpu_rsp.dat;
        // hold through the ack cycle, then release
        @(negedge wb_clk);
        cpu_req = '0;
    endtask

    task automatic write_and_check(input logic [2:0] idx, input logic [31:0] val,
                                   input logic [31:0] mask, input string what);
        logic [31:0] got;
        cpu_access(1'b1, idx, val, got);
        cpu_access(1'b0, idx, 32'h0, got);
        expect_eq(got, val & mask, what);
    endtask

    // request outside the register window must never be acked
    task automatic probe_miss();
        @(negedge wb_clk);
        cpu_req.cyc = 1'b1;
        cpu_req.we  = 1'b0;
        cpu_req.adr = {DMA_ADDR ^ 8'h01, 24'h000018};
        for (int i = 0; i < 8; i++) begin
            @(negedge wb_clk);
            expect_eq({31'h0, cpu_rsp.ack}, 32'h0, "ack outside the register window");
        end
        cpu_req = '0;
    endtask

    task automatic push_block();
        for (int i = 0; i < BANK_SIZE; i++) begin
            @(negedge wb_clk);
            sample_valid = 1'b1;
            sample_data  = next_sample;
            next_sample  = next_sample + 16'd1;
        end
        @(negedge wb_clk);
        sample_valid = 1'b0;
    endtask

    // memory model with random ack delay and checks on each write
    task automatic serve_writes(input int blk, input dma_pkg::sample_t first);
        logic [23:0]      exp_addr;
        logic [31:0]      exp_data;
        dma_pkg::sample_t exp_sample;
        int               delay;
        int               n;
        for (int k = 0; k < PER_BLOCK; k++) begin
            exp_addr   = START_ADDR + 24'(2 * blk) + 24'(k) * {8'h00, STEP};
            exp_sample = first + 16'(k);
            exp_data   = exp_addr[1] ? {exp_sample, 16'h0000} : {16'h0000, exp_sample};
            n = 0;
            while (!dma_req.cyc) begin
                @(negedge wb_clk);
                n++;
                if (n > WAIT_LIMIT) give_up("no write on the memory bus");
            end
            draw_delay(delay);
            repeat (delay) @(negedge wb_clk);
            dma_ack = 1'b1;
            #1;
            expect_eq(dma_req.adr, {8'h00, exp_addr[23:2], 2'b00}, "write address");
            expect_eq({28'h0, dma_req.sel}, exp_addr[1] ? 32'hC : 32'h3, "byte select");
            expect_eq(dma_req.dat, exp_data, "write data");
            @(negedge wb_clk);
            dma_ack = 1'b0;
        end
    endtask

    task automatic wait_block_done();
        int n;
        n = 0;
        while (!block_done) begin
            @(negedge wb_clk);
            n++;
            if (n > WAIT_LIMIT) give_up("block-done never set");
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge wb_clk);
            expect_eq({31'h0, dma_req.cyc}, 32'h0, "memory cycle without a start");
        end
    endtask

    initial begin
        dma_pkg::sample_t first;
        logic [31:0]      status;
        repeat (4) @(negedge wb_clk);
        wb_rst = 1'b0;

        // register readback with unused upper bits
        write_and_check(dma_pkg::REG_ADDR, {8'hFF, START_ADDR}, 32'h00FF_FFFF, "addr reg");
        write_and_check(dma_pkg::REG_STEP, {16'hABCD, STEP}, 32'h0000_FFFF, "step reg");
        write_and_check(dma_pkg::REG_CYCLES, {16'h1234, 16'(NUM_BLOCKS)}, 32'h0000_FFFF,
                        "cycles reg");
        write_and_check(dma_pkg::REG_BLOCKS, {16'h00FF, 16'(PER_BLOCK)}, 32'h0000_FFFF,
                        "blocks reg");
        write_and_check(dma_pkg::REG_MATCH, {8'h77, MATCH_ADDR}, 32'h00FF_FFFF, "match reg");
        cpu_access(1'b0, dma_pkg::REG_STATUS, 32'h0, status);
        expect_eq(status, 32'h0, "status before start");
        probe_miss();

        // single run without repeat
        cpu_access(1'b1, dma_pkg::REG_START, 32'h0, status);
        for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
            first = next_sample;
            push_block();
            serve_writes(blk, first);
            wait_block_done();
            expect_eq({31'h0, xfer_done}, (blk == NUM_BLOCKS - 1) ? 32'h1 : 32'h0, "done flag");
        end
        cpu_access(1'b0, dma_pkg::REG_STATUS, 32'h0, status);
        expect_eq(status, 32'h7, "status after run");
        expect_eq({29'h0, xfer_match, block_done, xfer_done}, 32'h7, "status pins after run");

        // a further full bank must not start a transfer
        push_block();
        expect_quiet(20);
        expect_eq({31'h0, xfer_match}, 32'h1, "match flag held until stop");

        cpu_access(1'b1, dma_pkg::REG_STOP, 32'h0, status);
        expect_eq({29'h0, xfer_match, block_done, xfer_done}, 32'h0, "flags after stop");
        cpu_access(1'b0, dma_pkg::REG_STATUS, 32'h0, status);
        expect_eq(status, 32'h0, "status after stop");
        push_block();
        expect_quiet(20);

        if (DUT.u_asserts.violations == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

/* verilog.f */
source/dma_pkg.sv
source/chip_select.sv
source/sample_capture.sv
source/sample_buffer.sv
source/dma.sv
source/dma_subsystem.sv
tb/dma_subsystem_asserts.sv
tb/dma_subsystem_tb.sv
